//--- src/udp_echo_pkg.sv
// UDP echo shared width typedefs, header and beat structs, filter state enum, defaults
`default_nettype none

package udp_echo_pkg;

    // Field widths of the UDP and IP headers
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;

    // Payload stream widths
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;

    // UDP header with the IP fields the echo path needs
    typedef struct packed {
        ttl_t        ip_ttl;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        udp_len_t    length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload beat
    typedef struct packed {
        beat_data_t tdata;
        beat_keep_t tkeep;
        logic       tlast;
        // Bad frame marker, passed through untouched
        logic       tuser;
    } axis_beat_t;

    // Per-datagram state of the port filter
    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_PASS,
        FILT_DROP
    } filter_state_t;

    // 192.168.1.128
    localparam ip_addr_t  DEF_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam udp_port_t DEF_ECHO_PORT = 16'd1234;

    localparam ttl_t      DEF_REPLY_TTL = 8'd64;

    // 1024 payload beats of buffering
    localparam int        DEF_FIFO_ADDR_WIDTH = 10;

endpackage

`default_nettype wire

//--- src/udp_port_filter.sv
// UDP port filter: echo port match, reply header register, payload pass/drop gating
`timescale 1ns/1ns
`default_nettype none

module udp_port_filter #(
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEF_LOCAL_IP,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEF_ECHO_PORT,
    parameter udp_echo_pkg::ttl_t      REPLY_TTL = udp_echo_pkg::DEF_REPLY_TTL
) (
    input  logic                     clk,
    input  logic                     rst,

    // Received UDP header
    input  udp_echo_pkg::udp_hdr_t   in_hdr,
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,

    // Received payload
    input  udp_echo_pkg::axis_beat_t in_beat,
    input  logic                     in_beat_valid,
    output logic                     in_beat_ready,

    // Reply header
    output udp_echo_pkg::udp_hdr_t   out_hdr,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,

    // Payload towards the FIFO
    output udp_echo_pkg::axis_beat_t pass_beat,
    output logic                     pass_valid,
    input  logic                     pass_ready
);

    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;

    logic hdr_match;
    logic hdr_fire;
    logic last_fire;

    assign hdr_match = (in_hdr.dest_port == ECHO_PORT);

    // A matching header must wait for a free reply slot,
    // anything else is taken right away
    assign in_hdr_ready = (state == FILT_IDLE) && (!out_hdr_valid || !hdr_match);
    assign hdr_fire     = in_hdr_valid && in_hdr_ready;

    assign last_fire = in_beat_valid && in_beat_ready && in_beat.tlast;

    always_comb begin
        state_next = state;
        case (state)
            FILT_IDLE: begin
                if (hdr_fire) begin
                    state_next = hdr_match ? FILT_PASS : FILT_DROP;
                end
            end
            FILT_PASS, FILT_DROP: begin
                if (last_fire) begin
                    state_next = FILT_IDLE;
                end
            end
            default: begin
                state_next = FILT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Payload gating, combinational in pass state
    always_comb begin
        case (state)
            FILT_PASS: in_beat_ready = pass_ready;
            FILT_DROP: in_beat_ready = 1'b1;
            default:   in_beat_ready = 1'b0;
        endcase
    end

    assign pass_beat  = in_beat;
    assign pass_valid = (state == FILT_PASS) && in_beat_valid;

    // One-entry reply slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (hdr_fire && hdr_match) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    // Addresses and ports swap, local IP becomes the source
    always_ff @(posedge clk) begin
        if (hdr_fire && hdr_match) begin
            out_hdr.ip_ttl      <= REPLY_TTL;
            out_hdr.source_ip   <= LOCAL_IP;
            out_hdr.dest_ip     <= in_hdr.source_ip;
            out_hdr.source_port <= in_hdr.dest_port;
            out_hdr.dest_port   <= in_hdr.source_port;
            out_hdr.length      <= in_hdr.length;
            // No UDP checksum on the reply
            out_hdr.checksum    <= 16'd0;
        end
    end

endmodule

`default_nettype wire

//--- src/payload_fifo.sv
// Synchronous payload beat FIFO with a registered read stage
`timescale 1ns/1ns
`default_nettype none

module payload_fifo #(
    parameter int ADDR_WIDTH = udp_echo_pkg::DEF_FIFO_ADDR_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,

    // Write side
    input  udp_echo_pkg::axis_beat_t wr_beat,
    input  logic                     wr_valid,
    output logic                     wr_ready,

    // Read side
    output udp_echo_pkg::axis_beat_t rd_beat,
    output logic                     rd_valid,
    input  logic                     rd_ready
);

    import udp_echo_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    axis_beat_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic wr_fire;
    logic out_free;
    logic load_mem;
    logic load_bypass;
    logic mem_write;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                       (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign wr_ready = !mem_full;
    assign wr_fire  = wr_valid && wr_ready;

    // Output stage takes a new beat when empty or being consumed
    assign out_free = !rd_valid || rd_ready;
    assign load_mem = out_free && !mem_empty;

    // With nothing stored, a fresh beat goes straight to the output stage
    assign load_bypass = out_free && mem_empty && wr_fire;
    assign mem_write   = wr_fire && !load_bypass;

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (mem_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (load_mem || load_bypass) begin
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    // Stored beats always go first, keeping order
    always_ff @(posedge clk) begin
        if (load_mem) begin
            rd_beat <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end else if (load_bypass) begin
            rd_beat <= wr_beat;
        end
    end

endmodule

`default_nettype wire

//--- src/udp_echo_top.sv
// UDP echo top level: port filter, payload FIFO and first-byte LED latch
`timescale 1ns/1ns
`default_nettype none

module udp_echo_top #(
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP        = udp_echo_pkg::DEF_LOCAL_IP,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT       = udp_echo_pkg::DEF_ECHO_PORT,
    parameter udp_echo_pkg::ttl_t      REPLY_TTL       = udp_echo_pkg::DEF_REPLY_TTL,
    parameter int                      FIFO_ADDR_WIDTH = udp_echo_pkg::DEF_FIFO_ADDR_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::udp_hdr_t   in_hdr,
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,

    input  udp_echo_pkg::axis_beat_t in_beat,
    input  logic                     in_beat_valid,
    output logic                     in_beat_ready,

    output udp_echo_pkg::udp_hdr_t   out_hdr,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,

    output udp_echo_pkg::axis_beat_t out_beat,
    output logic                     out_beat_valid,
    input  logic                     out_beat_ready,

    output logic [7:0]               led
);

    import udp_echo_pkg::*;

    // Filter to FIFO link
    axis_beat_t pass_beat;
    logic       pass_valid;
    logic       pass_ready;

    logic out_fire;
    logic frame_start;

    udp_port_filter #(
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT),
        .REPLY_TTL (REPLY_TTL)
    ) u_filter (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (in_hdr),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_beat       (in_beat),
        .in_beat_valid (in_beat_valid),
        .in_beat_ready (in_beat_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .pass_beat     (pass_beat),
        .pass_valid    (pass_valid),
        .pass_ready    (pass_ready)
    );

    payload_fifo #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (pass_beat),
        .wr_valid (pass_valid),
        .wr_ready (pass_ready),
        .rd_beat  (out_beat),
        .rd_valid (out_beat_valid),
        .rd_ready (out_beat_ready)
    );

    assign out_fire = out_beat_valid && out_beat_ready;

    // Show the first payload byte of each echoed frame
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start <= 1'b1;
            led         <= 8'd0;
        end else if (out_fire) begin
            if (frame_start) begin
                led <= out_beat.tdata[7:0];
            end
            // Re-arm for the next frame on its last beat
            frame_start <= out_beat.tlast;
        end
    end

endmodule

`default_nettype wire

//--- tb/udp_echo_assertions.sv
// Concurrent handshake and reset assertions bound to the UDP echo top level
`timescale 1ns/1ns
`default_nettype none

module udp_echo_assertions (
    input logic                     clk,
    input logic                     rst,
    input udp_echo_pkg::udp_hdr_t   out_hdr,
    input logic                     out_hdr_valid,
    input logic                     out_hdr_ready,
    input udp_echo_pkg::axis_beat_t out_beat,
    input logic                     out_beat_valid,
    input logic                     out_beat_ready,
    input logic [7:0]               led
);

    // A waiting reply header holds until taken
    hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr)
    ) else $error("Reply header changed or dropped while waiting for ready");

    // Same rule on the payload output
    beat_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_beat_valid && !out_beat_ready |=> out_beat_valid && $stable(out_beat)
    ) else $error("Payload beat changed or dropped while waiting for ready");

    // Nothing active in the first cycle out of reset
    reset_idle: assert property (
        @(posedge clk) $fell(rst) |-> !out_hdr_valid && !out_beat_valid && (led == 8'd0)
    ) else $error("Outputs active in the first cycle after reset");

endmodule

`default_nettype wire

//--- tb/udp_echo_tb.sv
// UDP echo testbench with clock, reset, stimulus, reference model, scoreboard and report
`timescale 1ns/1ns
`default_nettype none

module udp_echo_tb;

    import udp_echo_pkg::*;

    localparam int HANDSHAKE_LIMIT = 5000;
    localparam int DRAIN_LIMIT     = 10000;
    localparam int STALL_CYCLES    = 3000;

    // Output ready patterns
    localparam int READY_FULL   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_STALL  = 2;

    logic       clk = 1'b0;
    logic       rst;
    udp_hdr_t   in_hdr;
    logic       in_hdr_valid;
    logic       in_hdr_ready;
    axis_beat_t in_beat;
    logic       in_beat_valid;
    logic       in_beat_ready;
    udp_hdr_t   out_hdr;
    logic       out_hdr_valid;
    logic       out_hdr_ready = 1'b1;
    axis_beat_t out_beat;
    logic       out_beat_valid;
    logic       out_beat_ready = 1'b1;
    logic [7:0] led;

    // Scoreboard state
    udp_hdr_t   hdr_q[$];
    axis_beat_t beat_q[$];
    logic [7:0] expected_led = 8'd0;
    logic       frame_start = 1'b1;
    logic       fifo_full_seen = 1'b0;
    int         ready_mode = READY_FULL;
    int         ready_req = READY_FULL;
    string      test_name = "reset";
    int         output_errors = 0;
    int         flow_errors = 0;

    udp_echo_top u_dut (.*);

    bind udp_echo_top udp_echo_assertions u_assertions (
        .clk            (clk),
        .rst            (rst),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_beat       (out_beat),
        .out_beat_valid (out_beat_valid),
        .out_beat_ready (out_beat_ready),
        .led            (led)
    );

    always #2 clk = ~clk;

    // Reply for an echoed datagram
    function automatic udp_hdr_t expected_reply(input udp_hdr_t h);
        udp_hdr_t r;
        r.ip_ttl      = DEF_REPLY_TTL;
        r.source_ip   = DEF_LOCAL_IP;
        r.dest_ip     = h.source_ip;
        r.source_port = h.dest_port;
        r.dest_port   = h.source_port;
        r.length      = h.length;
        r.checksum    = 16'd0;
        return r;
    endfunction

    task automatic check_hdr(input udp_hdr_t exp, input udp_hdr_t act);
        if (act !== exp) begin
            output_errors++;
            $display("CHECK FAILED %s reply header expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_beat(input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            output_errors++;
            $display("CHECK FAILED %s payload beat expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_led(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            output_errors++;
            $display("CHECK FAILED %s led expected %02h actual %02h", test_name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d on outputs, %0d in flow control", output_errors, flow_errors);
        if (output_errors + flow_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Entered at a falling edge with valid raised and left at the falling edge after the transfer
    task automatic wait_accept(input logic is_hdr);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            #1;
            taken = is_hdr ? in_hdr_ready : in_beat_ready;
            @(posedge clk);
            if (!taken) begin
                waited++;
                if (waited > HANDSHAKE_LIMIT) begin
                    flow_errors++;
                    $display("Timeout: the DUT did not accept a %s in %s",
                             is_hdr ? "header" : "payload beat", test_name);
                    finish_run();
                end
                @(negedge clk);
            end
        end
        @(negedge clk);
    endtask

    task automatic send_datagram(input logic match, input int beats);
        udp_hdr_t   h;
        axis_beat_t b;
        int         i;
        h.ip_ttl      = ttl_t'($urandom);
        h.source_ip   = $urandom;
        h.dest_ip     = $urandom;
        h.source_port = udp_port_t'($urandom);
        h.dest_port   = DEF_ECHO_PORT;
        while (!match && h.dest_port == DEF_ECHO_PORT) begin
            h.dest_port = udp_port_t'($urandom);
        end
        h.length   = udp_len_t'(8 + 8 * beats);
        h.checksum = 16'($urandom);
        if (match) begin
            hdr_q.push_back(expected_reply(h));
        end
        in_hdr       = h;
        in_hdr_valid = 1'b1;
        wait_accept(1'b1);
        in_hdr_valid = 1'b0;
        for (i = 0; i < beats; i++) begin
            b.tdata = {$urandom, $urandom};
            b.tlast = (i == beats - 1);
            b.tkeep = b.tlast ? (8'hff >> $urandom_range(0, 7)) : 8'hff;
            b.tuser = ($urandom_range(0, 7) == 0);
            if (match) begin
                beat_q.push_back(b);
            end
            in_beat       = b;
            in_beat_valid = 1'b1;
            wait_accept(1'b0);
            in_beat_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (hdr_q.size() != 0 || beat_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                flow_errors++;
                $display("Timeout: %0d headers and %0d beats never came out in %s",
                         hdr_q.size(), beat_q.size(), test_name);
                finish_run();
            end
        end
    endtask

    task automatic compare_outputs();
        axis_beat_t exp_beat;
        check_led(expected_led, led);
        if (ready_mode == READY_STALL && in_beat_valid && !in_beat_ready) begin
            fifo_full_seen = 1'b1;
        end
        if (out_hdr_valid && out_hdr_ready) begin
            if (hdr_q.size() == 0) begin
                output_errors++;
                $display("Reply header sent with no echoed datagram pending in %s", test_name);
            end else begin
                check_hdr(hdr_q.pop_front(), out_hdr);
            end
        end
        if (out_beat_valid && out_beat_ready) begin
            if (beat_q.size() == 0) begin
                output_errors++;
                $display("Payload beat sent with none pending in %s", test_name);
            end else begin
                exp_beat = beat_q.pop_front();
                check_beat(exp_beat, out_beat);
                // LED takes the first byte of a frame on the next clock
                if (frame_start) begin
                    expected_led = exp_beat.tdata[7:0];
                end
                frame_start = exp_beat.tlast;
            end
        end
    endtask

    // Output readies change on the falling edge and outputs are compared once settled
    always @(negedge clk) begin
        case (ready_mode)
            READY_RANDOM: begin
                out_hdr_ready  = ($urandom_range(0, 3) != 0);
                out_beat_ready = ($urandom_range(0, 3) != 0);
            end
            READY_STALL: begin
                out_hdr_ready  = ($urandom_range(0, 1) != 0);
                out_beat_ready = 1'b0;
            end
            default: begin
                out_hdr_ready  = 1'b1;
                out_beat_ready = 1'b1;
            end
        endcase
        #1;
        if (!rst) begin
            compare_outputs();
        end
        ready_mode = ready_req;
    end

    initial begin
        void'($urandom(32'hd665_5d59));
        rst           = 1'b1;
        in_hdr        = '0;
        in_hdr_valid  = 1'b0;
        in_beat       = '0;
        in_beat_valid = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (out_hdr_valid || out_beat_valid || led != 8'd0 || in_beat_ready || !in_hdr_ready) begin
            flow_errors++;
            $display("The DUT outputs were not in their reset state after reset");
        end
        @(negedge clk);

        test_name = "single_match";
        send_datagram(1'b1, 4);
        wait_drain();

        test_name = "drop_other_ports";
        repeat (3) begin
            send_datagram(1'b0, int'($urandom_range(1, 12)));
        end
        send_datagram(1'b1, 7);
        wait_drain();

        test_name = "mixed_stream";
        repeat (40) begin
            send_datagram($urandom_range(0, 1) == 1, int'($urandom_range(1, 12)));
        end
        wait_drain();

        test_name = "random_ready";
        ready_req = READY_RANDOM;
        repeat (40) begin
            send_datagram($urandom_range(0, 1) == 1, int'($urandom_range(1, 12)));
        end
        wait_drain();

        // Payload output held long enough to fill the FIFO
        test_name = "fifo_stall";
        fork
            begin
                ready_req = READY_STALL;
                repeat (STALL_CYCLES) @(negedge clk);
                ready_req = READY_RANDOM;
            end
            begin
                repeat (100) begin
                    send_datagram(1'b1, 12);
                end
            end
        join
        wait_drain();
        if (!fifo_full_seen) begin
            flow_errors++;
            $display("The payload FIFO never filled during the output stall");
        end

        // Room for any stray output to show up
        repeat (16) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
src/udp_echo_pkg.sv
src/udp_port_filter.sv
src/payload_fifo.sv
src/udp_echo_top.sv
tb/udp_echo_assertions.sv
tb/udp_echo_tb.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

obj_dir/Vudp_echo_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module udp_echo_tb -f filelist.f -o Vudp_echo_tb

run: obj_dir/Vudp_echo_tb
	obj_dir/Vudp_echo_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
